/* avr_io_pkg.sv */
package avr_io_pkg;

	// bus and port widths
	localparam int IO_ADR_W  = 6;
	localparam int DATA_W    = 8;
	localparam int PORTB_W   = 8;
	localparam int IRQ_COUNT = 45;

	// port B register addresses
	localparam logic [IO_ADR_W-1:0] PINB_ADR  = 6'h03;
	localparam logic [IO_ADR_W-1:0] DDRB_ADR  = 6'h04;
	localparam logic [IO_ADR_W-1:0] PORTB_ADR = 6'h05;

	// flag and control registers
	localparam logic [IO_ADR_W-1:0] TIFR0_ADR = 6'h15;
	localparam logic [IO_ADR_W-1:0] PCIFR_ADR = 6'h1B;
	localparam logic [IO_ADR_W-1:0] GTCCR_ADR = 6'h23;

	// timer/counter 0 registers
	localparam logic [IO_ADR_W-1:0] TCCR0B_ADR = 6'h25;
	localparam logic [IO_ADR_W-1:0] TCNT0_ADR  = 6'h26;
	localparam logic [IO_ADR_W-1:0] OCR0A_ADR  = 6'h27;

	// bit positions
	localparam int TOV0_BIT    = 0;
	localparam int OCF0A_BIT   = 1;
	localparam int PCIF0_BIT   = 0;
	localparam int PSRSYNC_BIT = 0;
	localparam int CS0_LSB     = 0;
	localparam int CS0_W       = 3;

	// vector numbers, same as the core's irq line index
	localparam logic [5:0] PCINT0_VEC   = 6'd3;
	localparam logic [5:0] TC0_CMPA_VEC = 6'd14;
	localparam logic [5:0] TC0_OVF_VEC  = 6'd16;

	// clock select, 6 and 7 fall through to stop
	localparam logic [CS0_W-1:0] CS_STOP    = 3'd0;
	localparam logic [CS0_W-1:0] CS_DIV1    = 3'd1;
	localparam logic [CS0_W-1:0] CS_DIV8    = 3'd2;
	localparam logic [CS0_W-1:0] CS_DIV64   = 3'd3;
	localparam logic [CS0_W-1:0] CS_DIV256  = 3'd4;
	localparam logic [CS0_W-1:0] CS_DIV1024 = 3'd5;

endpackage

/* prescaler0.sv */
`timescale 1ns/1ps

module prescaler0 (
	input  logic cp2_i,
	input  logic rst_i,
	input  logic psr_clr_i,
	output logic en8_o,
	output logic en64_o,
	output logic en256_o,
	output logic en1024_o
);

	// free running, wraps at 1024
	logic [9:0] psc_cnt;

	always_ff @(posedge cp2_i) begin
		if (rst_i) begin
			psc_cnt <= '0;
		end else if (psr_clr_i) begin
			// PSRSYNC restarts all taps together
			psc_cnt <= '0;
		end else begin
			psc_cnt <= psc_cnt + 10'd1;
		end
	end

	// one cycle pulse when the low bits are all ones
	always_comb begin
		en8_o    = &psc_cnt[2:0];
		en64_o   = &psc_cnt[5:0];
		en256_o  = &psc_cnt[7:0];
		en1024_o = &psc_cnt[9:0];
	end

endmodule

/* timer_counter0.sv */
`timescale 1ns/1ps

module timer_counter0 import avr_io_pkg::*; (
	input  logic                cp2_i,
	input  logic                rst_i,
	input  logic [IO_ADR_W-1:0] adr_i,
	input  logic                iore_i,
	input  logic                iowe_i,
	input  logic [DATA_W-1:0]   dbus_i,
	input  logic                irqack_i,
	input  logic [5:0]          irqackad_i,
	output logic [DATA_W-1:0]   dbus_o,
	output logic                out_en_o,
	output logic                tov0_o,
	output logic                ocf0a_o
);

	logic             sel_tccr0b, sel_tcnt0, sel_ocr0a, sel_tifr0, sel_gtccr;
	logic [CS0_W-1:0] cs0;
	logic [DATA_W-1:0] tcnt0, ocr0a, tcnt0_inc;
	logic [DATA_W-1:0] tccr0b_rd, tifr0_rd;
	logic             en8, en64, en256, en1024;
	logic             cnt_en, psr_clr, wr_tcnt;
	logic             tov0_set, tov0_clr, ocf0a_set, ocf0a_clr;

	assign sel_tccr0b = (adr_i == TCCR0B_ADR);
	assign sel_tcnt0  = (adr_i == TCNT0_ADR);
	assign sel_ocr0a  = (adr_i == OCR0A_ADR);
	assign sel_tifr0  = (adr_i == TIFR0_ADR);
	assign sel_gtccr  = (adr_i == GTCCR_ADR);
	assign out_en_o   = iore_i & (sel_tccr0b | sel_tcnt0 | sel_ocr0a | sel_tifr0 | sel_gtccr);

	assign psr_clr = iowe_i & sel_gtccr & dbus_i[PSRSYNC_BIT];

	prescaler0 u_prescaler0 (
		.cp2_i     (cp2_i),
		.rst_i     (rst_i),
		.psr_clr_i (psr_clr),
		.en8_o     (en8),
		.en64_o    (en64),
		.en256_o   (en256),
		.en1024_o  (en1024)
	);

	always_comb begin
		case (cs0)
			CS_DIV1:    cnt_en = 1'b1;
			CS_DIV8:    cnt_en = en8;
			CS_DIV64:   cnt_en = en64;
			CS_DIV256:  cnt_en = en256;
			CS_DIV1024: cnt_en = en1024;
			CS_STOP:    cnt_en = 1'b0;
			default:    cnt_en = 1'b0;
		endcase
	end

	// a cpu load of TCNT0 blocks the count and its flags
	assign wr_tcnt   = iowe_i & sel_tcnt0;
	assign tcnt0_inc = tcnt0 + 8'd1;
	assign tov0_set  = cnt_en & ~wr_tcnt & (tcnt0 == 8'hFF);
	assign ocf0a_set = cnt_en & ~wr_tcnt & (tcnt0_inc == ocr0a);
	assign tov0_clr  = (iowe_i & sel_tifr0 & dbus_i[TOV0_BIT]) |
		(irqack_i & (irqackad_i == TC0_OVF_VEC));
	assign ocf0a_clr = (iowe_i & sel_tifr0 & dbus_i[OCF0A_BIT]) |
		(irqack_i & (irqackad_i == TC0_CMPA_VEC));

	always_ff @(posedge cp2_i) begin
		if (rst_i) begin
			cs0   <= CS_STOP;
			ocr0a <= '0;
			tcnt0 <= '0;
		end else begin
			if (iowe_i && sel_tccr0b) begin
				cs0 <= dbus_i[CS0_LSB +: CS0_W];
			end
			if (iowe_i && sel_ocr0a) begin
				ocr0a <= dbus_i;
			end
			if (wr_tcnt) begin
				tcnt0 <= dbus_i;
			end else if (cnt_en) begin
				tcnt0 <= tcnt0_inc;
			end
		end
	end

	// set beats clear in the same cycle
	always_ff @(posedge cp2_i) begin
		if (rst_i) begin
			tov0_o  <= 1'b0;
			ocf0a_o <= 1'b0;
		end else begin
			if (tov0_set) tov0_o <= 1'b1;
			else if (tov0_clr) tov0_o <= 1'b0;
			if (ocf0a_set) ocf0a_o <= 1'b1;
			else if (ocf0a_clr) ocf0a_o <= 1'b0;
		end
	end

	always_comb begin
		tccr0b_rd = '0;
		tccr0b_rd[CS0_LSB +: CS0_W] = cs0;
		tifr0_rd = '0;
		tifr0_rd[TOV0_BIT]  = tov0_o;
		tifr0_rd[OCF0A_BIT] = ocf0a_o;
	end

	// GTCCR falls to default and reads as zero
	always_comb begin
		case (adr_i)
			TCCR0B_ADR: dbus_o = tccr0b_rd;
			TCNT0_ADR:  dbus_o = tcnt0;
			OCR0A_ADR:  dbus_o = ocr0a;
			TIFR0_ADR:  dbus_o = tifr0_rd;
			default:    dbus_o = '0;
		endcase
	end

endmodule

/* port_b.sv */
`timescale 1ns/1ps

module port_b import avr_io_pkg::*; (
	input  logic                cp2_i,
	input  logic                rst_i,
	input  logic [IO_ADR_W-1:0] adr_i,
	input  logic                iore_i,
	input  logic                iowe_i,
	input  logic [DATA_W-1:0]   dbus_i,
	input  logic                irqack_i,
	input  logic [5:0]          irqackad_i,
	input  logic [PORTB_W-1:0]  pinb_i,
	output logic [DATA_W-1:0]   dbus_o,
	output logic                out_en_o,
	output logic                pcif0_o,
	output logic [PORTB_W-1:0]  dd_o,
	output logic [PORTB_W-1:0]  pv_o,
	output logic [PORTB_W-1:0]  pu_o
);

	logic               sel_pinb, sel_ddrb, sel_portb, sel_pcifr;
	logic [PORTB_W-1:0] ddrb, portb;
	logic [PORTB_W-1:0] pin_meta, pin_sync, pin_hist;
	logic               pc_set, pc_clr;
	logic [DATA_W-1:0]  pcifr_rd;

	assign sel_pinb  = (adr_i == PINB_ADR);
	assign sel_ddrb  = (adr_i == DDRB_ADR);
	assign sel_portb = (adr_i == PORTB_ADR);
	assign sel_pcifr = (adr_i == PCIFR_ADR);
	assign out_en_o  = iore_i & (sel_pinb | sel_ddrb | sel_portb | sel_pcifr);

	always_ff @(posedge cp2_i) begin
		if (rst_i) begin
			ddrb  <= '0;
			portb <= '0;
		end else begin
			if (iowe_i && sel_ddrb) begin
				ddrb <= dbus_i;
			end
			// writing PINB flips the selected PORTB bits
			if (iowe_i && sel_pinb) begin
				portb <= portb ^ dbus_i;
			end else if (iowe_i && sel_portb) begin
				portb <= dbus_i;
			end
		end
	end

	// two stage synchronizer plus one stage of history
	always_ff @(posedge cp2_i) begin
		pin_meta <= pinb_i;
		pin_sync <= pin_meta;
		pin_hist <= pin_sync;
	end

	assign pc_set = |(pin_sync ^ pin_hist);
	assign pc_clr = (iowe_i & sel_pcifr & dbus_i[PCIF0_BIT]) |
		(irqack_i & (irqackad_i == PCINT0_VEC));

	always_ff @(posedge cp2_i) begin
		if (rst_i) begin
			pcif0_o <= 1'b0;
		end else if (pc_set) begin
			pcif0_o <= 1'b1;
		end else if (pc_clr) begin
			pcif0_o <= 1'b0;
		end
	end

	// pull-up on inputs driven high in PORTB
	assign dd_o = ddrb;
	assign pv_o = portb;
	assign pu_o = portb & ~ddrb;

	always_comb begin
		pcifr_rd = '0;
		pcifr_rd[PCIF0_BIT] = pcif0_o;
		case (adr_i)
			PINB_ADR:  dbus_o = pin_sync;
			DDRB_ADR:  dbus_o = ddrb;
			PORTB_ADR: dbus_o = portb;
			PCIFR_ADR: dbus_o = pcifr_rd;
			default:   dbus_o = '0;
		endcase
	end

endmodule

/* io_bus_combine.sv */
`timescale 1ns/1ps

module io_bus_combine import avr_io_pkg::*; (
	input  logic [DATA_W-1:0] tc0_dbus_i,
	input  logic [DATA_W-1:0] pb_dbus_i,
	input  logic              tc0_en_i,
	input  logic              pb_en_i,
	input  logic              tov0_i,
	input  logic              ocf0a_i,
	input  logic              pcif0_i,
	output logic [DATA_W-1:0] dbus_o,
	output logic              irq_pending_o,
	output logic [5:0]        irq_vector_o
);

	logic [IRQ_COUNT-1:0] irq_lines;

	// timer has first claim on the read bus
	assign dbus_o = tc0_en_i ? tc0_dbus_i :
		pb_en_i ? pb_dbus_i : '0;

	always_comb begin
		irq_lines = '0;
		irq_lines[PCINT0_VEC]   = pcif0_i;
		irq_lines[TC0_CMPA_VEC] = ocf0a_i;
		irq_lines[TC0_OVF_VEC]  = tov0_i;
	end

	assign irq_pending_o = |irq_lines;

	// scan from the top so the lowest set line is left last
	always_comb begin
		irq_vector_o = '0;
		for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
			if (irq_lines[i]) begin
				irq_vector_o = 6'(i);
			end
		end
	end

endmodule

/* avr_io_top.sv */
`timescale 1ns/1ps

module avr_io_top import avr_io_pkg::*; (
	input  logic                cp2_i,
	input  logic                rst_i,
	input  logic [IO_ADR_W-1:0] adr_i,
	input  logic                iore_i,
	input  logic                iowe_i,
	input  logic [DATA_W-1:0]   dbus_i,
	input  logic                irqack_i,
	input  logic [5:0]          irqackad_i,
	input  logic [PORTB_W-1:0]  pinb_i,
	output logic [DATA_W-1:0]   dbus_o,
	output logic                irq_pending_o,
	output logic [5:0]          irq_vector_o,
	output logic [PORTB_W-1:0]  dd_o,
	output logic [PORTB_W-1:0]  pv_o,
	output logic [PORTB_W-1:0]  pu_o
);

	logic [DATA_W-1:0] tc0_dbus, pb_dbus;
	logic              tc0_en, pb_en;
	logic              tov0, ocf0a, pcif0;

	timer_counter0 u_tc0 (
		.cp2_i      (cp2_i),
		.rst_i      (rst_i),
		.adr_i      (adr_i),
		.iore_i     (iore_i),
		.iowe_i     (iowe_i),
		.dbus_i     (dbus_i),
		.irqack_i   (irqack_i),
		.irqackad_i (irqackad_i),
		.dbus_o     (tc0_dbus),
		.out_en_o   (tc0_en),
		.tov0_o     (tov0),
		.ocf0a_o    (ocf0a)
	);

	port_b u_port_b (
		.cp2_i      (cp2_i),
		.rst_i      (rst_i),
		.adr_i      (adr_i),
		.iore_i     (iore_i),
		.iowe_i     (iowe_i),
		.dbus_i     (dbus_i),
		.irqack_i   (irqack_i),
		.irqackad_i (irqackad_i),
		.pinb_i     (pinb_i),
		.dbus_o     (pb_dbus),
		.out_en_o   (pb_en),
		.pcif0_o    (pcif0),
		.dd_o       (dd_o),
		.pv_o       (pv_o),
		.pu_o       (pu_o)
	);

	// read select and interrupt encode
	io_bus_combine u_combine (
		.tc0_dbus_i    (tc0_dbus),
		.pb_dbus_i     (pb_dbus),
		.tc0_en_i      (tc0_en),
		.pb_en_i       (pb_en),
		.tov0_i        (tov0),
		.ocf0a_i       (ocf0a),
		.pcif0_i       (pcif0),
		.dbus_o        (dbus_o),
		.irq_pending_o (irq_pending_o),
		.irq_vector_o  (irq_vector_o)
	);

endmodule

/* avr_io_sva.sv */
`timescale 1ns/1ps

module avr_io_sva import avr_io_pkg::*; (
	input logic               cp2_i,
	input logic               rst_i,
	input logic               iore_i,
	input logic [DATA_W-1:0]  dbus_o,
	input logic               irq_pending_o,
	input logic [5:0]         irq_vector_o,
	input logic [PORTB_W-1:0] dd_o,
	input logic [PORTB_W-1:0] pv_o,
	input logic [PORTB_W-1:0] pu_o
);

	int fail_count = 0;

	// no used line sits at index zero
	a_pending_vec: assert property (@(posedge cp2_i) disable iff (rst_i)
		irq_pending_o == (irq_vector_o != 6'd0))
		else begin
			fail_count++;
			$error("irq_pending_o disagrees with irq_vector_o");
		end

	a_idle_bus: assert property (@(posedge cp2_i) disable iff (rst_i)
		!iore_i |-> dbus_o == '0)
		else begin
			fail_count++;
			$error("dbus_o driven while iore_i is low");
		end

	// first cycle out of reset
	a_reset_clean: assert property (@(posedge cp2_i)
		$fell(rst_i) |-> (dd_o == '0 && pv_o == '0 && pu_o == '0 &&
		!irq_pending_o && irq_vector_o == '0 && dbus_o == '0))
		else begin
			fail_count++;
			$error("outputs not cleared by reset");
		end

endmodule

bind avr_io_top avr_io_sva u_sva (
	.cp2_i         (cp2_i),
	.rst_i         (rst_i),
	.iore_i        (iore_i),
	.dbus_o        (dbus_o),
	.irq_pending_o (irq_pending_o),
	.irq_vector_o  (irq_vector_o),
	.dd_o          (dd_o),
	.pv_o          (pv_o),
	.pu_o          (pu_o)
);

/* tb_avr_io.sv */
`timescale 1ns/1ps

module tb_avr_io import avr_io_pkg::*; ();

	localparam int POLL_LIMIT = 3000;

	typedef enum logic [3:0] {
		OP_WR, OP_RD, OP_PINS, OP_POLL, OP_ACK, OP_IDLE, OP_VEC, OP_OUTS, OP_SAME, OP_MARK
	} op_t;

	// one row of the stimulus table
	typedef struct packed {
		op_t        op;
		logic [5:0] adr;
		logic [7:0] data;
		logic [7:0] mask;
		logic [7:0] expv;
		logic [7:0] tol;
	} step_t;

	logic        cp2, rst, iore, iowe, irqack, irq_pending;
	logic [5:0]  adr, irqackad, irq_vector;
	logic [7:0]  dbus_wr, dbus_rd, pinb, dd, pv, pu;
	step_t       steps [0:63];
	int          n_steps, checks, errors, failed_tests, test_err_base;
	int          seed = 95027;
	logic [7:0]  last_rd;
	string       test_names [1:6];

	avr_io_top dut (
		.cp2_i         (cp2),
		.rst_i         (rst),
		.adr_i         (adr),
		.iore_i        (iore),
		.iowe_i        (iowe),
		.dbus_i        (dbus_wr),
		.irqack_i      (irqack),
		.irqackad_i    (irqackad),
		.pinb_i        (pinb),
		.dbus_o        (dbus_rd),
		.irq_pending_o (irq_pending),
		.irq_vector_o  (irq_vector),
		.dd_o          (dd),
		.pv_o          (pv),
		.pu_o          (pu)
	);

	always #20 cp2 = ~cp2;

	task automatic check_value(input string name, input logic [7:0] got,
			input logic [7:0] expv, input int tol);
		int diff;
		diff = int'(got) - int'(expv);
		if (diff < 0) diff = -diff;
		checks++;
		if (diff > tol) begin
			errors++;
			$display("Error %s: got 0x%02h, expected 0x%02h", name, got, expv);
		end
	endtask

	// value checks plus failed assertions
	function automatic int error_total();
		return errors + dut.u_sva.fail_count;
	endfunction

	task automatic drive_bus(input logic [5:0] a, input logic [7:0] d,
			input logic re, input logic we);
		adr      <= a;
		dbus_wr  <= d;
		iore     <= re;
		iowe     <= we;
		irqack   <= 1'b0;
		irqackad <= '0;
	endtask

	task automatic add_step(input op_t op, input logic [5:0] a, input logic [7:0] data,
			input logic [7:0] mask, input logic [7:0] expv, input logic [7:0] tol);
		steps[n_steps] = '{op, a, data, mask, expv, tol};
		n_steps++;
	endtask

	task automatic build_table();
		logic [7:0] rnd_dd, rnd_pv, tog, pins;
		rnd_dd = $random(seed);
		rnd_pv = $random(seed);
		tog    = $random(seed);
		pins   = $random(seed);
		// register write-back and pull-up rule
		add_step(OP_WR, DDRB_ADR, rnd_dd, 0, 0, 0);
		add_step(OP_WR, PORTB_ADR, rnd_pv, 0, 0, 0);
		add_step(OP_RD, DDRB_ADR, 0, 8'hFF, rnd_dd, 0);
		add_step(OP_RD, PORTB_ADR, 0, 8'hFF, rnd_pv, 0);
		add_step(OP_OUTS, 0, rnd_dd, 0, rnd_pv, 0);
		add_step(OP_MARK, 0, 1, 0, 0, 0);
		// PIN write toggle and the input synchronizer
		add_step(OP_WR, PINB_ADR, tog, 0, 0, 0);
		add_step(OP_RD, PORTB_ADR, 0, 8'hFF, rnd_pv ^ tog, 0);
		add_step(OP_PINS, 0, pins, 0, 0, 0);
		add_step(OP_IDLE, 0, 2, 0, 0, 0);
		add_step(OP_RD, PINB_ADR, 0, 8'hFF, pins, 0);
		add_step(OP_RD, 6'h10, 0, 8'hFF, 8'h00, 0);
		add_step(OP_WR, PCIFR_ADR, 8'h01, 0, 0, 0);
		add_step(OP_VEC, 0, 0, 0, 0, 0);
		add_step(OP_MARK, 0, 2, 0, 0, 0);
		// pin change flag and its acknowledge
		pins = pins ^ 8'h01;
		add_step(OP_PINS, 0, pins, 0, 0, 0);
		add_step(OP_POLL, PCIFR_ADR, 0, 8'h01, 8'h01, 0);
		add_step(OP_VEC, 0, 1, 0, PCINT0_VEC, 0);
		add_step(OP_ACK, 0, PCINT0_VEC, 0, 0, 0);
		add_step(OP_RD, PCIFR_ADR, 0, 8'h01, 8'h00, 0);
		add_step(OP_VEC, 0, 0, 0, 0, 0);
		add_step(OP_MARK, 0, 3, 0, 0, 0);
		// full speed count through compare and overflow
		add_step(OP_WR, OCR0A_ADR, 8'h80, 0, 0, 0);
		add_step(OP_WR, TCCR0B_ADR, CS_DIV1, 0, 0, 0);
		add_step(OP_WR, TCNT0_ADR, 8'h70, 0, 0, 0);
		add_step(OP_POLL, TIFR0_ADR, 0, 8'h02, 8'h02, 0);
		add_step(OP_VEC, 0, 1, 0, TC0_CMPA_VEC, 0);
		add_step(OP_POLL, TIFR0_ADR, 0, 8'h01, 8'h01, 0);
		add_step(OP_VEC, 0, 1, 0, TC0_CMPA_VEC, 0);
		add_step(OP_WR, TIFR0_ADR, 8'h02, 0, 0, 0);
		add_step(OP_VEC, 0, 1, 0, TC0_OVF_VEC, 0);
		add_step(OP_ACK, 0, TC0_OVF_VEC, 0, 0, 0);
		add_step(OP_VEC, 0, 0, 0, 0, 0);
		add_step(OP_WR, TCCR0B_ADR, CS_STOP, 0, 0, 0);
		add_step(OP_MARK, 0, 4, 0, 0, 0);
		// divide by 8 from a cleared prescaler
		add_step(OP_WR, GTCCR_ADR, 8'h01, 0, 0, 0);
		add_step(OP_WR, TCNT0_ADR, 8'h00, 0, 0, 0);
		add_step(OP_WR, TCCR0B_ADR, CS_DIV8, 0, 0, 0);
		add_step(OP_IDLE, 0, 80, 0, 0, 0);
		add_step(OP_RD, TCNT0_ADR, 0, 8'hFF, 8'd80 / 8'd8, 1);
		add_step(OP_WR, TCCR0B_ADR, CS_STOP, 0, 0, 0);
		add_step(OP_RD, TCNT0_ADR, 0, 8'h00, 8'h00, 0);
		add_step(OP_IDLE, 0, 50, 0, 0, 0);
		add_step(OP_SAME, TCNT0_ADR, 0, 0, 0, 0);
		add_step(OP_MARK, 0, 5, 0, 0, 0);
		// one overflow with a pin change on top of it
		add_step(OP_WR, TCNT0_ADR, 8'hFF, 0, 0, 0);
		add_step(OP_WR, TCCR0B_ADR, CS_DIV1, 0, 0, 0);
		add_step(OP_WR, TCCR0B_ADR, CS_STOP, 0, 0, 0);
		add_step(OP_POLL, TIFR0_ADR, 0, 8'h01, 8'h01, 0);
		add_step(OP_PINS, 0, pins ^ 8'h80, 0, 0, 0);
		add_step(OP_POLL, PCIFR_ADR, 0, 8'h01, 8'h01, 0);
		add_step(OP_VEC, 0, 1, 0, PCINT0_VEC, 0);
		add_step(OP_ACK, 0, PCINT0_VEC, 0, 0, 0);
		add_step(OP_VEC, 0, 1, 0, TC0_OVF_VEC, 0);
		add_step(OP_ACK, 0, TC0_OVF_VEC, 0, 0, 0);
		add_step(OP_VEC, 0, 0, 0, 0, 0);
		add_step(OP_MARK, 0, 6, 0, 0, 0);
	endtask

	task automatic run_step(input step_t s);
		int         waited;
		bit         found;
		logic [7:0] prev;
		waited = 0;
		found  = 1'b0;
		prev   = last_rd;
		case (s.op)
			OP_WR: begin
				@(posedge cp2);
				drive_bus(s.adr, s.data, 1'b0, 1'b1);
			end
			OP_RD, OP_SAME: begin
				@(posedge cp2);
				drive_bus(s.adr, '0, 1'b1, 1'b0);
				@(negedge cp2);
				last_rd = dbus_rd;
				if (s.op == OP_SAME) begin
					check_value($sformatf("dbus_o[0x%02h] repeat", s.adr), dbus_rd, prev, 0);
				end else if (s.mask != 8'h00) begin
					check_value($sformatf("dbus_o[0x%02h]", s.adr), dbus_rd & s.mask,
						s.expv & s.mask, s.tol);
				end
			end
			OP_PINS: begin
				@(posedge cp2);
				drive_bus('0, '0, 1'b0, 1'b0);
				pinb <= s.data;
			end
			OP_POLL: begin
				while (!found && waited < POLL_LIMIT) begin
					@(posedge cp2);
					drive_bus(s.adr, '0, 1'b1, 1'b0);
					@(negedge cp2);
					found = ((dbus_rd & s.mask) == s.expv);
					waited++;
				end
				checks++;
				if (!found) begin
					errors++;
					$display("register 0x%02h timed out waiting for 0x%02h under mask 0x%02h",
						s.adr, s.expv, s.mask);
				end
			end
			OP_ACK: begin
				@(posedge cp2);
				drive_bus('0, '0, 1'b0, 1'b0);
				irqack   <= 1'b1;
				irqackad <= s.data[5:0];
			end
			OP_IDLE: begin
				repeat (s.data) begin
					@(posedge cp2);
					drive_bus('0, '0, 1'b0, 1'b0);
				end
			end
			OP_VEC, OP_OUTS: begin
				@(posedge cp2);
				drive_bus('0, '0, 1'b0, 1'b0);
				@(negedge cp2);
				if (s.op == OP_VEC) begin
					check_value("irq_vector_o", {2'b00, irq_vector}, s.expv, 0);
					check_value("irq_pending_o", {7'd0, irq_pending}, s.data, 0);
				end else begin
					check_value("dd_o", dd, s.data, 0);
					check_value("pv_o", pv, s.expv, 0);
					// pull-up where PORTB is one on an input pin
					check_value("pu_o", pu, s.expv & ~s.data, 0);
				end
			end
			OP_MARK: begin
				if (error_total() == test_err_base) begin
					$display("test %0d %s: passed", s.data, test_names[s.data]);
				end else begin
					failed_tests++;
					$display("test %0d %s: failed, %0d errors", s.data, test_names[s.data],
						error_total() - test_err_base);
				end
				test_err_base = error_total();
			end
			default: ;
		endcase
	endtask

	initial begin
		cp2      = 1'b0;
		rst      = 1'b1;
		adr      = '0;
		iore     = 1'b0;
		iowe     = 1'b0;
		dbus_wr  = '0;
		irqack   = 1'b0;
		irqackad = '0;
		pinb     = '0;
		last_rd  = '0;
		n_steps  = 0;
		checks   = 0;
		errors   = 0;
		failed_tests  = 0;
		test_err_base = 0;
		test_names[1] = "register write-back";
		test_names[2] = "pin toggle and sync";
		test_names[3] = "pin change";
		test_names[4] = "timer divide by 1";
		test_names[5] = "timer divide by 8";
		test_names[6] = "priority order";
		build_table();
		repeat (4) @(posedge cp2);
		rst <= 1'b0;
		for (int i = 0; i < n_steps; i++) begin
			run_step(steps[i]);
		end
		@(posedge cp2);
		drive_bus('0, '0, 1'b0, 1'b0);
		$display("tests 6, failed %0d, checks %0d, errors %0d", failed_tests, checks,
			error_total());
		if (error_total() == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
avr_io_pkg.sv
prescaler0.sv
timer_counter0.sv
port_b.sv
io_bus_combine.sv
avr_io_top.sv
avr_io_sva.sv
tb_avr_io.sv
